// File: id_pkg.sv
// Shared types, opcodes and instruction field views for the decode stage
package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic data types
  //////////////////////////////////////////////////////////////////////

  // Index into the 32-entry integer register file
  typedef logic [4:0] rf_addr_t;

  // Architectural data word, also used for instructions and the PC
  typedef logic [31:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes of the supported RV32I subset
  // Anything else in bits 6..0 decodes as illegal
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_LUI    = 7'h37
  } opcode_e;

  // Operations handed to the execute stage
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // Minor opcode values in funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // Word-sized access for lw and sw
  localparam logic [2:0] F3_WORD    = 3'b010;

  // Values of funct7 for register-register operations
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  // Selects sub instead of add
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  //////////////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////////////

  // Register view of the word
  // The funct7 and rs2 fields together also carry the I-type immediate
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  // Store view of the word, where the immediate is split around rs2 and rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // Both views over the same 32 bits
  typedef union packed {
    r_fmt_t r;
    s_fmt_t s;
  } instr_u;

endpackage

// File: id_pipe_if.sv
// Valid/ready pipe interfaces from fetch to decode and from decode to execute

// Fetch-to-decode pipe, one instruction and its PC per transfer
interface if_id_if;
  import id_pkg::*;

  logic  valid;
  logic  ready;
  word_t instr;
  word_t pc;

  modport fetch  (output valid, instr, pc, input ready);
  modport decode (input valid, instr, pc, output ready);
endinterface

// Decode-to-execute pipe carrying the decoded item and its operands
interface id_ex_if;
  import id_pkg::*;

  logic     valid;
  logic     ready;
  logic     alu_en;
  logic     lsu_en;
  logic     lsu_we;
  logic     rf_we;
  rf_addr_t rd;
  alu_op_e  alu_op;
  word_t    operand_a;
  word_t    operand_b;
  logic     illegal;

  modport decode (
    output valid, alu_en, lsu_en, lsu_we, rf_we, rd, alu_op,
    output operand_a, operand_b, illegal,
    input  ready
  );
  modport execute (
    input  valid, alu_en, lsu_en, lsu_we, rf_we, rd, alu_op,
    input  operand_a, operand_b, illegal,
    output ready
  );
endinterface

// File: id_decoder.sv
// RV32I subset decoder producing enables, ALU operation, immediate and illegal flag
module id_decoder (
  input  id_pkg::word_t   instr_i,
  output logic            alu_en_o,
  output logic            lsu_en_o,
  output logic            lsu_we_o,
  output logic            rf_we_o,
  output logic            use_imm_o,
  output logic            illegal_o,
  output id_pkg::alu_op_e alu_op_o,
  output id_pkg::word_t   imm_o,
  output logic [1:0]      rf_re_o
);
  import id_pkg::*;

  instr_u      instr;
  logic [11:0] imm_i12;
  logic [11:0] imm_s12;
  logic        alu_en;
  logic        lsu_en;
  logic        lsu_we;
  logic        rf_we;
  logic        use_imm;
  logic        illegal;
  alu_op_e     alu_op;
  word_t       imm;
  logic [1:0]  rf_re;

  assign instr = instr_i;

  // The I immediate sits where funct7 and rs2 are in the register view
  assign imm_i12 = {instr.r.funct7, instr.r.rs2};
  // The S immediate is rebuilt from its two halves in the store view
  assign imm_s12 = {instr.s.imm_hi, instr.s.imm_lo};

  //////////////////////////////////////////////////////////////////////
  // Opcode, funct3 and funct7 decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_en  = 1'b0;
    lsu_en  = 1'b0;
    lsu_we  = 1'b0;
    rf_we   = 1'b0;
    use_imm = 1'b0;
    illegal = 1'b0;
    alu_op  = ALU_ADD;
    imm     = '0;
    rf_re   = 2'b00;

    case (instr.r.opcode)
      OPCODE_OP: begin
        // Only add accepts the alternate funct7
        if (instr.r.funct7 == F7_ALT && instr.r.funct3 == F3_ADD_SUB) begin
          alu_op = ALU_SUB;
        end else if (instr.r.funct7 == F7_BASE) begin
          case (instr.r.funct3)
            F3_ADD_SUB: alu_op = ALU_ADD;
            F3_SLT:     alu_op = ALU_SLT;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    illegal = 1'b1;
          endcase
        end else begin
          illegal = 1'b1;
        end
        if (!illegal) begin
          alu_en = 1'b1;
          rf_we  = 1'b1;
          rf_re  = 2'b11;
        end
      end
      OPCODE_OP_IMM: begin
        imm = {{20{imm_i12[11]}}, imm_i12};
        // Shifts and slti are outside the subset
        case (instr.r.funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
        if (!illegal) begin
          alu_en  = 1'b1;
          rf_we   = 1'b1;
          rf_re   = 2'b01;
          use_imm = 1'b1;
        end
      end
      OPCODE_LOAD: begin
        // Address is rs1 plus the I immediate
        imm = {{20{imm_i12[11]}}, imm_i12};
        if (instr.r.funct3 == F3_WORD) begin
          lsu_en  = 1'b1;
          rf_we   = 1'b1;
          rf_re   = 2'b01;
          use_imm = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPCODE_STORE: begin
        imm = {{20{imm_s12[11]}}, imm_s12};
        if (instr.s.funct3 == F3_WORD) begin
          lsu_en  = 1'b1;
          lsu_we  = 1'b1;
          rf_re   = 2'b11;
          use_imm = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPCODE_LUI: begin
        // No register read, so operand a stays zero and the sum is the U immediate
        alu_en  = 1'b1;
        rf_we   = 1'b1;
        use_imm = 1'b1;
        imm     = {instr_i[31:12], 12'h000};
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // Only the legal leaves of the decode raise an enable
  assign illegal_o = illegal;
  assign alu_en_o  = alu_en;
  assign lsu_en_o  = lsu_en;
  assign lsu_we_o  = lsu_we;
  assign rf_we_o   = rf_we;
  assign use_imm_o = use_imm;
  assign rf_re_o   = rf_re;
  assign alu_op_o  = alu_op;
  assign imm_o     = imm;

  always_comb begin
    if (illegal_o) begin
      a_illegal_no_side_effects : assert (!(alu_en_o || lsu_en_o || lsu_we_o || rf_we_o))
        else $error("Illegal instruction raised an enable or a register write");
    end
  end

endmodule

// File: id_regfile.sv
// Integer register file with parameterized read ports and a hard-wired zero register
module id_regfile #(
  parameter int unsigned REGFILE_NUM_READ_PORTS = 2
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  id_pkg::rf_addr_t raddr_i [REGFILE_NUM_READ_PORTS],
  output id_pkg::word_t    rdata_o [REGFILE_NUM_READ_PORTS],
  input  logic             we_i,
  input  id_pkg::rf_addr_t waddr_i,
  input  id_pkg::word_t    wdata_i
);
  import id_pkg::*;

  // Registers x1 to x31 have storage, x0 has none
  localparam int unsigned NUM_WORDS = 31;

  word_t mem_q [1:NUM_WORDS];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // A write shows up in the array on the edge after it is presented
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 1; i <= NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes aimed at x0 are dropped here
      mem_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < REGFILE_NUM_READ_PORTS; p++) begin : g_read
    // Reads are asynchronous and address zero never touches the array
    assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : mem_q[raddr_i[p]];

    // x0 still reads zero on the cycle after someone wrote to it
    a_x0_reads_zero : assert property (@(posedge clk) disable iff (!arst_n_i)
      (we_i && (waddr_i == '0)) ##1 (raddr_i[p] == '0) |-> (rdata_o[p] == '0))
      else $error("Read of x0 returned a nonzero value after a write to x0");
  end

endmodule

// File: id_stage.sv
// Decode stage with operand forwarding, halt and kill control and the execute pipe register
module id_stage #(
  parameter int unsigned REGFILE_NUM_READ_PORTS = 2
) (
  input  logic             clk,
  input  logic             arst_n_i,
  if_id_if.decode          if_id,
  id_ex_if.decode          id_ex,
  input  logic             halt_i,
  input  logic             kill_i,
  output id_pkg::rf_addr_t rf_raddr_o [REGFILE_NUM_READ_PORTS],
  input  id_pkg::word_t    rf_rdata_i [REGFILE_NUM_READ_PORTS],
  input  logic             wb_we_i,
  input  id_pkg::rf_addr_t wb_waddr_i,
  input  id_pkg::word_t    wb_wdata_i
);
  import id_pkg::*;

  instr_u     instr;
  rf_addr_t   rs1;
  rf_addr_t   rs2;
  logic       dec_alu_en;
  logic       dec_lsu_en;
  logic       dec_lsu_we;
  logic       dec_rf_we;
  logic       dec_use_imm;
  logic       dec_illegal;
  alu_op_e    dec_alu_op;
  word_t      dec_imm;
  logic [1:0] dec_rf_re;
  word_t      fwd_a;
  word_t      fwd_b;
  word_t      operand_a;
  word_t      operand_b;
  logic       id_ready;
  logic       load;
  logic       valid_q;
  logic       alu_en_q;
  logic       lsu_en_q;
  logic       lsu_we_q;
  logic       rf_we_q;
  logic       illegal_q;
  rf_addr_t   rd_q;
  alu_op_e    alu_op_q;
  word_t      operand_a_q;
  word_t      operand_b_q;

  assign instr = if_id.instr;
  assign rs1   = instr.r.rs1;
  assign rs2   = instr.r.rs2;

  id_decoder u_decoder (
    .instr_i   (if_id.instr),
    .alu_en_o  (dec_alu_en),
    .lsu_en_o  (dec_lsu_en),
    .lsu_we_o  (dec_lsu_we),
    .rf_we_o   (dec_rf_we),
    .use_imm_o (dec_use_imm),
    .illegal_o (dec_illegal),
    .alu_op_o  (dec_alu_op),
    .imm_o     (dec_imm),
    .rf_re_o   (dec_rf_re)
  );

  //////////////////////////////////////////////////////////////////////
  // Register reads and write-back forwarding
  //////////////////////////////////////////////////////////////////////

  // Port 0 serves rs1 and port 1 serves rs2
  assign rf_raddr_o[0] = rs1;
  assign rf_raddr_o[1] = rs2;
  // Any further ports are parked on x0
  for (genvar p = 2; p < REGFILE_NUM_READ_PORTS; p++) begin : g_spare_port
    assign rf_raddr_o[p] = '0;
  end

  // A write-back in this cycle is not yet in the array, so take it directly
  assign fwd_a = (wb_we_i && (wb_waddr_i == rs1) && (rs1 != '0)) ? wb_wdata_i : rf_rdata_i[0];
  assign fwd_b = (wb_we_i && (wb_waddr_i == rs2) && (rs2 != '0)) ? wb_wdata_i : rf_rdata_i[1];

  // Unread operands are zero, which gives lui its zero base
  assign operand_a = dec_rf_re[0] ? fwd_a : '0;
  assign operand_b = dec_use_imm ? dec_imm : (dec_rf_re[1] ? fwd_b : '0);

  //////////////////////////////////////////////////////////////////////
  // Handshake control and output register
  //////////////////////////////////////////////////////////////////////

  // Kill always accepts and throws the item away, halt blocks new items
  assign id_ready = kill_i | (~halt_i & (~valid_q | id_ex.ready));
  assign load     = if_id.valid & id_ready & ~kill_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      alu_en_q  <= 1'b0;
      lsu_en_q  <= 1'b0;
      lsu_we_q  <= 1'b0;
      rf_we_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else if (load) begin
      valid_q   <= 1'b1;
      alu_en_q  <= dec_alu_en;
      lsu_en_q  <= dec_lsu_en;
      lsu_we_q  <= dec_lsu_we;
      rf_we_q   <= dec_rf_we;
      illegal_q <= dec_illegal;
    end else if (kill_i || id_ex.ready) begin
      // Either execute took the item or it was killed
      valid_q   <= 1'b0;
      alu_en_q  <= 1'b0;
      lsu_en_q  <= 1'b0;
      lsu_we_q  <= 1'b0;
      rf_we_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rd_q        <= instr.r.rd;
      alu_op_q    <= dec_alu_op;
      operand_a_q <= operand_a;
      operand_b_q <= operand_b;
    end
  end

  assign if_id.ready     = id_ready;
  assign id_ex.valid     = valid_q;
  assign id_ex.alu_en    = alu_en_q;
  assign id_ex.lsu_en    = lsu_en_q;
  assign id_ex.lsu_we    = lsu_we_q;
  assign id_ex.rf_we     = rf_we_q;
  assign id_ex.illegal   = illegal_q;
  assign id_ex.rd        = rd_q;
  assign id_ex.alu_op    = alu_op_q;
  assign id_ex.operand_a = operand_a_q;
  assign id_ex.operand_b = operand_b_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Halt stalls fetch and no fresh item shows up behind an empty output
  a_halt : assert property (@(posedge clk) disable iff (!arst_n_i)
    (halt_i && !kill_i && !id_ex.valid) |-> !if_id.ready ##1 !id_ex.valid)
    else $error("Halt let a new item into the output register");

  a_kill : assert property (@(posedge clk) disable iff (!arst_n_i)
    kill_i |-> if_id.ready ##1 !id_ex.valid)
    else $error("Kill did not empty the output register");

  a_valid_instr : assert property (@(posedge clk) disable iff (!arst_n_i)
    (if_id.valid && if_id.ready && !kill_i) |-> !$isunknown({if_id.instr, if_id.pc}))
    else $error("Accepted instruction has unknown bits");

  // x0 stays zero through both the regfile and the forwarding path
  a_x0_operand_a : assert property (@(posedge clk) disable iff (!arst_n_i)
    (if_id.valid && dec_rf_re[0] && (rs1 == '0)) |-> (operand_a == '0))
    else $error("Read of x0 gave a nonzero operand a");

  a_x0_operand_b : assert property (@(posedge clk) disable iff (!arst_n_i)
    (if_id.valid && dec_rf_re[1] && !dec_use_imm && (rs2 == '0)) |-> (operand_b == '0))
    else $error("Read of x0 gave a nonzero operand b");

endmodule

// File: id_top.sv
// Decode top level joining the stage and register file behind plain pipe ports
module id_top #(
  parameter int unsigned REGFILE_NUM_READ_PORTS = 2
) (
  input  logic             clk,
  input  logic             arst_n_i,
  // Fetch side
  input  logic             if_valid_i,
  input  id_pkg::word_t    if_instr_i,
  input  id_pkg::word_t    if_pc_i,
  output logic             if_ready_o,
  // Execute side
  input  logic             ex_ready_i,
  output logic             ex_valid_o,
  output logic             ex_alu_en_o,
  output logic             ex_lsu_en_o,
  output logic             ex_lsu_we_o,
  output logic             ex_rf_we_o,
  output id_pkg::rf_addr_t ex_rd_o,
  output id_pkg::alu_op_e  ex_alu_op_o,
  output id_pkg::word_t    ex_operand_a_o,
  output id_pkg::word_t    ex_operand_b_o,
  output logic             ex_illegal_o,
  // Controller
  input  logic             halt_i,
  input  logic             kill_i,
  // Write-back
  input  logic             wb_we_i,
  input  id_pkg::rf_addr_t wb_waddr_i,
  input  id_pkg::word_t    wb_wdata_i
);
  import id_pkg::*;

  if_id_if if_id ();
  id_ex_if id_ex ();

  rf_addr_t rf_raddr [REGFILE_NUM_READ_PORTS];
  word_t    rf_rdata [REGFILE_NUM_READ_PORTS];

  // Fetch pipe onto the interface
  assign if_id.valid = if_valid_i;
  assign if_id.instr = if_instr_i;
  assign if_id.pc    = if_pc_i;
  assign if_ready_o  = if_id.ready;

  // Execute pipe off the interface
  assign id_ex.ready    = ex_ready_i;
  assign ex_valid_o     = id_ex.valid;
  assign ex_alu_en_o    = id_ex.alu_en;
  assign ex_lsu_en_o    = id_ex.lsu_en;
  assign ex_lsu_we_o    = id_ex.lsu_we;
  assign ex_rf_we_o     = id_ex.rf_we;
  assign ex_rd_o        = id_ex.rd;
  assign ex_alu_op_o    = id_ex.alu_op;
  assign ex_operand_a_o = id_ex.operand_a;
  assign ex_operand_b_o = id_ex.operand_b;
  assign ex_illegal_o   = id_ex.illegal;

  id_stage #(
    .REGFILE_NUM_READ_PORTS (REGFILE_NUM_READ_PORTS)
  ) u_stage (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .if_id      (if_id),
    .id_ex      (id_ex),
    .halt_i     (halt_i),
    .kill_i     (kill_i),
    .rf_raddr_o (rf_raddr),
    .rf_rdata_i (rf_rdata),
    .wb_we_i    (wb_we_i),
    .wb_waddr_i (wb_waddr_i),
    .wb_wdata_i (wb_wdata_i)
  );

  // The same write-back port updates the array and feeds forwarding
  id_regfile #(
    .REGFILE_NUM_READ_PORTS (REGFILE_NUM_READ_PORTS)
  ) u_regfile (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .raddr_i  (rf_raddr),
    .rdata_o  (rf_rdata),
    .we_i     (wb_we_i),
    .waddr_i  (wb_waddr_i),
    .wdata_i  (wb_wdata_i)
  );

endmodule

// File: tb_id_top.sv
// Directed testbench for the decode stage, checked against a reference register model
module tb_id_top;
  import id_pkg::*;

  localparam int PERIOD          = 100;
  localparam int SETTLE          = 10;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 40;

  logic     clk;
  logic     arst_n_i;
  logic     if_valid_i;
  word_t    if_instr_i;
  word_t    if_pc_i;
  logic     if_ready_o;
  logic     ex_ready_i;
  logic     ex_valid_o;
  logic     ex_alu_en_o;
  logic     ex_lsu_en_o;
  logic     ex_lsu_we_o;
  logic     ex_rf_we_o;
  rf_addr_t ex_rd_o;
  alu_op_e  ex_alu_op_o;
  word_t    ex_operand_a_o;
  word_t    ex_operand_b_o;
  logic     ex_illegal_o;
  logic     halt_i;
  logic     kill_i;
  logic     wb_we_i;
  rf_addr_t wb_waddr_i;
  word_t    wb_wdata_i;

  // Architectural register values as the write-back port should leave them
  word_t    ref_rf [32];
  // Destination registers of the items that execute has taken, in order
  rf_addr_t seen_q [$];
  string    test_name;
  integer   seed;
  word_t    rnd;

  // R-type rows in the order add, sub, and, or, xor, slt
  logic [6:0] f7_tbl [6] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00};
  logic [2:0] f3_tbl [6] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
  alu_op_e    op_tbl [6] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT};

  id_top #(
    .REGFILE_NUM_READ_PORTS (2)
  ) dut_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .if_valid_i     (if_valid_i),
    .if_instr_i     (if_instr_i),
    .if_pc_i        (if_pc_i),
    .if_ready_o     (if_ready_o),
    .ex_ready_i     (ex_ready_i),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rd_o        (ex_rd_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_illegal_o   (ex_illegal_o),
    .halt_i         (halt_i),
    .kill_i         (kill_i),
    .wb_we_i        (wb_we_i),
    .wb_waddr_i     (wb_waddr_i),
    .wb_wdata_i     (wb_wdata_i)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Execute takes an item on the rising edge that follows this sample
  always @(negedge clk) begin
    #SETTLE;
    if (arst_n_i && ex_valid_o && ex_ready_i) begin
      seen_q.push_back(ex_rd_o);
    end
  end

  // Six tests at forty cycles each, plus the reset cycles
  initial begin
    #(PERIOD * (NUM_TESTS * CYCLES_PER_TEST + 3));
    abort_run("Watchdog expired before all tests finished");
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_op(input string what, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s %s: expected %s, actual %s (%0d)",
                          test_name, what, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Instruction encoding and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic word_t r_type(input logic [6:0] f7, input rf_addr_t rs2,
                                   input rf_addr_t rs1, input logic [2:0] f3,
                                   input rf_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input rf_addr_t rs1,
                                   input logic [2:0] f3, input rf_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Word store, with the immediate split around the two source fields
  function automatic word_t s_type(input logic [11:0] imm, input rf_addr_t rs2,
                                   input rf_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input rf_addr_t rd);
    return {imm, rd, OPCODE_LUI};
  endfunction

  function automatic word_t sign_extend(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic in_subset(input logic [6:0] opc);
    return (opc == OPCODE_OP) || (opc == OPCODE_OP_IMM) || (opc == OPCODE_LOAD) ||
           (opc == OPCODE_STORE) || (opc == OPCODE_LUI);
  endfunction

  function automatic rf_addr_t nonzero_reg();
    word_t r;
    r = $random(seed);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  // Enters and leaves on a falling edge, one write per call
  task automatic wb_write(input rf_addr_t addr, input word_t data);
    wb_we_i    = 1'b1;
    wb_waddr_i = addr;
    wb_wdata_i = data;
    @(posedge clk);
    @(negedge clk);
    wb_we_i = 1'b0;
    if (addr != 5'd0) begin
      ref_rf[addr] = data;
    end
  endtask

  // Holds the item until the stage accepts it, then the result sits on the outputs
  task automatic issue(input word_t instr);
    if_valid_i = 1'b1;
    if_instr_i = instr;
    #SETTLE;
    while (!if_ready_o) begin
      @(negedge clk);
      #SETTLE;
    end
    @(posedge clk);
    @(negedge clk);
    if_valid_i = 1'b0;
    if_pc_i    = if_pc_i + 32'd4;
  endtask

  task automatic check_out(input string what, input logic alu_en, input logic lsu_en,
                           input logic lsu_we, input logic rf_we, input alu_op_e op,
                           input rf_addr_t rd, input word_t a, input word_t b);
    check_bit({what, " valid"}, 1'b1, ex_valid_o);
    check_bit({what, " illegal"}, 1'b0, ex_illegal_o);
    check_bit({what, " alu_en"}, alu_en, ex_alu_en_o);
    check_bit({what, " lsu_en"}, lsu_en, ex_lsu_en_o);
    check_bit({what, " lsu_we"}, lsu_we, ex_lsu_we_o);
    check_bit({what, " rf_we"}, rf_we, ex_rf_we_o);
    check_op({what, " alu_op"}, op, ex_alu_op_o);
    // A store has no destination because its rd field holds immediate bits
    if (rf_we) begin
      check_word({what, " rd"}, word_t'(rd), word_t'(ex_rd_o));
    end
    check_word({what, " operand a"}, a, ex_operand_a_o);
    check_word({what, " operand b"}, b, ex_operand_b_o);
  endtask

  task automatic expect_illegal(input string what);
    check_bit({what, " valid"}, 1'b1, ex_valid_o);
    check_bit({what, " illegal"}, 1'b1, ex_illegal_o);
    check_bit({what, " alu_en"}, 1'b0, ex_alu_en_o);
    check_bit({what, " lsu_en"}, 1'b0, ex_lsu_en_o);
    check_bit({what, " lsu_we"}, 1'b0, ex_lsu_we_o);
    check_bit({what, " rf_we"}, 1'b0, ex_rf_we_o);
    check_op({what, " alu_op"}, ALU_ADD, ex_alu_op_o);
  endtask

  task automatic imm_alu(input string what, input logic [2:0] f3, input alu_op_e op,
                         input logic [11:0] imm);
    rf_addr_t rs1;
    rf_addr_t rd;
    rs1 = nonzero_reg();
    rd  = nonzero_reg();
    issue(i_type(imm, rs1, f3, rd, OPCODE_OP_IMM));
    check_out(what, 1'b1, 1'b0, 1'b0, 1'b1, op, rd, ref_rf[rs1], sign_extend(imm));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic r_type_forwarding();
    rf_addr_t rs1;
    rf_addr_t rs2;
    rf_addr_t rd;
    word_t    fresh;
    test_name = "r_type_forwarding";
    for (int i = 1; i < 32; i++) begin
      rnd = $random(seed);
      wb_write(rf_addr_t'(i), rnd);
    end
    for (int k = 0; k < 6; k++) begin
      rs1 = nonzero_reg();
      rs2 = nonzero_reg();
      rd  = nonzero_reg();
      issue(r_type(f7_tbl[k], rs2, rs1, f3_tbl[k], rd));
      check_out(op_tbl[k].name(), 1'b1, 1'b0, 1'b0, 1'b1, op_tbl[k], rd,
                ref_rf[rs1], ref_rf[rs2]);
    end
    // The write to rs1 lands on the same edge that takes the add
    rs1   = nonzero_reg();
    rs2   = nonzero_reg();
    rd    = nonzero_reg();
    fresh = $random(seed);
    wb_we_i    = 1'b1;
    wb_waddr_i = rs1;
    wb_wdata_i = fresh;
    issue(r_type(7'h00, rs2, rs1, 3'b000, rd));
    wb_we_i     = 1'b0;
    ref_rf[rs1] = fresh;
    check_out("forwarded add", 1'b1, 1'b0, 1'b0, 1'b1, ALU_ADD, rd, ref_rf[rs1], ref_rf[rs2]);
  endtask

  task automatic immediates_and_memory();
    rf_addr_t    rs1;
    rf_addr_t    rs2;
    rf_addr_t    rd;
    logic [11:0] imm;
    test_name = "immediates_and_memory";
    // Most negative immediate checks the sign extension
    imm_alu("addi", 3'b000, ALU_ADD, 12'h800);
    rnd = $random(seed);
    imm_alu("andi", 3'b111, ALU_AND, rnd[11:0]);
    rnd = $random(seed);
    imm_alu("ori", 3'b110, ALU_OR, rnd[11:0]);
    rnd = $random(seed);
    imm_alu("xori", 3'b100, ALU_XOR, rnd[11:0]);
    rs1 = nonzero_reg();
    rs2 = nonzero_reg();
    rd  = nonzero_reg();
    rnd = $random(seed);
    imm = rnd[11:0];
    issue(i_type(imm, rs1, 3'b010, rd, OPCODE_LOAD));
    check_out("lw", 1'b0, 1'b1, 1'b0, 1'b1, ALU_ADD, rd, ref_rf[rs1], sign_extend(imm));
    issue(s_type(imm, rs2, rs1));
    check_out("sw", 1'b0, 1'b1, 1'b1, 1'b0, ALU_ADD, rd, ref_rf[rs1], sign_extend(imm));
    // Upper immediate added to a zero base
    rnd = $random(seed);
    issue(u_type(rnd[31:12], rd));
    check_out("lui", 1'b1, 1'b0, 1'b0, 1'b1, ALU_ADD, rd, 32'h0, {rnd[31:12], 12'h000});
  endtask

  task automatic illegal_encodings();
    word_t bad [4];
    test_name = "illegal_encodings";
    // Close neighbours of the subset are slli, lb, mul and sltu
    bad[0] = i_type(12'h003, 5'd1, 3'b001, 5'd2, OPCODE_OP_IMM);
    bad[1] = i_type(12'h010, 5'd1, 3'b000, 5'd2, OPCODE_LOAD);
    bad[2] = r_type(7'h01, 5'd3, 5'd1, 3'b000, 5'd2);
    bad[3] = r_type(7'h00, 5'd3, 5'd1, 3'b011, 5'd2);
    for (int k = 0; k < 4; k++) begin
      issue(bad[k]);
      expect_illegal($sformatf("neighbour %0d", k));
    end
    for (int k = 0; k < 6; k++) begin
      rnd = $random(seed);
      while (in_subset(rnd[6:0])) begin
        rnd = $random(seed);
      end
      issue(rnd);
      expect_illegal($sformatf("random %h", rnd));
    end
  endtask

  task automatic x0_reads();
    rf_addr_t rd;
    test_name = "x0_reads";
    rnd = $random(seed);
    wb_write(5'd0, rnd);
    rd = nonzero_reg();
    issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, rd));
    check_out("add x0 x0", 1'b1, 1'b0, 1'b0, 1'b1, ALU_ADD, rd, 32'h0, 32'h0);
    // A write-back to x0 in the same cycle must not reach the operand
    wb_we_i    = 1'b1;
    wb_waddr_i = 5'd0;
    wb_wdata_i = ~rnd;
    issue(i_type(12'h7ff, 5'd0, 3'b110, rd, OPCODE_OP_IMM));
    wb_we_i = 1'b0;
    check_out("ori x0", 1'b1, 1'b0, 1'b0, 1'b1, ALU_OR, rd, 32'h0, 32'h0000_07ff);
  endtask

  task automatic backpressure_and_halt();
    test_name = "backpressure_and_halt";
    // Drain whatever the previous test left in the output register
    @(negedge clk);
    seen_q.delete();
    ex_ready_i = 1'b0;
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    if_valid_i = 1'b1;
    if_instr_i = r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6);
    repeat (3) begin
      #SETTLE;
      check_bit("ready under back-pressure", 1'b0, if_ready_o);
      check_bit("valid held", 1'b1, ex_valid_o);
      check_word("rd held", 32'd5, word_t'(ex_rd_o));
      check_word("operand a held", ref_rf[1], ex_operand_a_o);
      check_word("operand b held", ref_rf[2], ex_operand_b_o);
      @(negedge clk);
    end
    ex_ready_i = 1'b1;
    issue(r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6));
    check_out("after release", 1'b1, 1'b0, 1'b0, 1'b1, ALU_AND, 5'd6, ref_rf[2], ref_rf[3]);
    halt_i     = 1'b1;
    if_valid_i = 1'b1;
    if_instr_i = r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd7);
    repeat (3) begin
      #SETTLE;
      check_bit("ready under halt", 1'b0, if_ready_o);
      @(negedge clk);
      check_bit("no item under halt", 1'b0, ex_valid_o);
    end
    halt_i = 1'b0;
    issue(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd7));
    check_out("after halt", 1'b1, 1'b0, 1'b0, 1'b1, ALU_XOR, 5'd7, ref_rf[3], ref_rf[4]);
    @(negedge clk);
    check_word("items taken", 32'd3, word_t'(seen_q.size()));
    check_word("first item", 32'd5, word_t'(seen_q[0]));
    check_word("second item", 32'd6, word_t'(seen_q[1]));
    check_word("third item", 32'd7, word_t'(seen_q[2]));
  endtask

  task automatic kill_drops_item();
    test_name = "kill_drops_item";
    @(negedge clk);
    seen_q.delete();
    ex_ready_i = 1'b0;
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
    // Kill with one item held and another waiting at the input
    kill_i     = 1'b1;
    if_valid_i = 1'b1;
    if_instr_i = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd9);
    #SETTLE;
    check_bit("ready under kill", 1'b1, if_ready_o);
    @(negedge clk);
    kill_i     = 1'b0;
    if_valid_i = 1'b0;
    check_bit("valid after kill", 1'b0, ex_valid_o);
    ex_ready_i = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_bit("killed item stays gone", 1'b0, ex_valid_o);
    end
    issue(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd10));
    check_out("after kill", 1'b1, 1'b0, 1'b0, 1'b1, ALU_OR, 5'd10, ref_rf[1], ref_rf[2]);
    @(negedge clk);
    check_word("items taken", 32'd1, word_t'(seen_q.size()));
    check_word("surviving item", 32'd10, word_t'(seen_q[0]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 8664;
    arst_n_i   = 1'b0;
    if_valid_i = 1'b0;
    if_instr_i = '0;
    if_pc_i    = 32'h0000_1000;
    ex_ready_i = 1'b1;
    halt_i     = 1'b0;
    kill_i     = 1'b0;
    wb_we_i    = 1'b0;
    wb_waddr_i = '0;
    wb_wdata_i = '0;
    for (int i = 0; i < 32; i++) begin
      ref_rf[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    test_name = "reset";
    check_bit("valid", 1'b0, ex_valid_o);
    check_bit("ready", 1'b1, if_ready_o);
    check_bit("alu_en", 1'b0, ex_alu_en_o);
    check_bit("lsu_en", 1'b0, ex_lsu_en_o);
    check_bit("lsu_we", 1'b0, ex_lsu_we_o);
    check_bit("rf_we", 1'b0, ex_rf_we_o);
    arst_n_i = 1'b1;
    @(negedge clk);
    r_type_forwarding();
    immediates_and_memory();
    illegal_encodings();
    x0_reads();
    backpressure_and_halt();
    kill_drops_item();
    $display("test passed");
    $finish;
  end

endmodule

// File: filelist.f
id_pkg.sv
id_pipe_if.sv
id_decoder.sv
id_regfile.sv
id_stage.sv
id_top.sv
tb_id_top.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

SIM = obj_dir/Vtb_id_top

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert -f filelist.f --top-module tb_id_top

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
